//--- dcache_pkg.sv
// Cache geometry, shared types and miss-handler states; imported by every cache module
package dcache_pkg;

   localparam int ADDR_W     = 32;
   localparam int WORD_W     = 32;
   localparam int WORD_BYTES = WORD_W / 8;
   localparam int LINE_WORDS = 4;
   localparam int SETS       = 16;
   localparam int WAYS       = 2;

   // Derived field widths of a physical address
   localparam int BYTE_W   = $clog2(WORD_BYTES);
   localparam int OFFSET_W = $clog2(LINE_WORDS);
   localparam int INDEX_W  = $clog2(SETS);
   localparam int WAY_W    = $clog2(WAYS);
   localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [WORD_BYTES-1:0] wmsk_t;
   typedef logic [7:0]            lane_t;

   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;
   typedef logic [WAY_W-1:0]    way_t;

   // Entry of the tag RAM
   typedef struct packed {
      tag_t tag;
      logic valid;
   } tag_entry_t;

   typedef enum logic [2:0] {
      BOOT, IDLE, REPLACE, WRITEBACK, REFILL, REPLAY
   } miss_state_e;

endpackage

//--- dcache_if.sv
// Internal links of the cache: lookup pipeline to arrays and miss handler, miss handler to arrays
`timescale 1ns/1ps

interface lookup_if import dcache_pkg::*; ();
   index_t s1_index;
   tag_t   s2_tag;
   index_t s2_index;
   offset_t s2_offset;
   wmsk_t  s2_wmsk;
   word_t  s2_wdat;
   logic   s2_valid;
   logic   ce;
   logic   hold;
   logic   hit;
   word_t  hit_data;
   logic   victim_dirty;

   modport lookup (output s1_index, s2_tag, s2_index, s2_offset, s2_wmsk, s2_wdat,
                   output s2_valid, ce, input hold, hit, hit_data);
   modport ways (input s1_index, s2_tag, s2_index, s2_offset, s2_wmsk, s2_wdat,
                 input s2_valid, ce, output hit, hit_data, victim_dirty);
   modport miss (input s2_tag, s2_index, s2_valid, hit, victim_dirty, output hold);
endinterface

interface fill_if import dcache_pkg::*; ();
   logic             ovr;
   index_t           index;
   offset_t          offset;
   way_t             way;
   word_t            wdata;
   tag_t             tag;
   logic             valid;
   logic [WAYS-1:0]  valid_we;
   logic [WAYS-1:0]  dirty_we;
   logic             data_we;
   tag_t             victim_tag;
   word_t            victim_data;

   modport miss (output ovr, index, offset, way, wdata, tag, valid, valid_we, dirty_we,
                 output data_we, input victim_tag, victim_data);
   modport ways (input ovr, index, offset, way, wdata, tag, valid, valid_we, dirty_we,
                 input data_we, output victim_tag, victim_data);
endinterface

//--- dcache_sram.sv
// Single-port synchronous RAM with lane write enables that holds tag entries or data words
`timescale 1ns/1ps

module dcache_sram #(
   parameter type entry_t = logic [31:0],
   parameter int  DEPTH   = 16,
   parameter int  LANES   = 1
) (
   input  logic                     clk,
   input  logic [$clog2(DEPTH)-1:0] addr,
   input  logic                     re,
   input  logic [LANES-1:0]         we,
   input  entry_t                   din,
   output entry_t                   dout
);

   logic [$bits(entry_t)-1:0] mem [DEPTH];
   logic [$bits(entry_t)-1:0] din_bits;

   assign din_bits = din;

   // Lane writes with a registered read of the word held before this edge
   always_ff @(posedge clk)
   begin
      for (int l = 0; l < LANES; l++)
      begin
         if (we[l])
            mem[addr][l*($bits(entry_t)/LANES) +: $bits(entry_t)/LANES] <=
               din_bits[l*($bits(entry_t)/LANES) +: $bits(entry_t)/LANES];
      end
      if (re)
         dout <= entry_t'(mem[addr]);
   end

   a_write_addr: assert property (@(posedge clk)
      (|we) |-> !$isunknown(addr) && (addr < DEPTH));

endmodule

//--- dcache_lookup.sv
// Request side of the cache that accepts core requests and runs the two lookup stages
`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  req_valid,
   output logic  req_ready,
   input  addr_t req_addr,
   input  wmsk_t req_wmsk,
   input  word_t req_wdat,
   output logic  resp_valid,
   output word_t resp_data,
   lookup_if.lookup lk
);

   logic    s1_valid;
   tag_t    s1_tag;
   index_t  s1_index;
   offset_t s1_offset;
   wmsk_t   s1_wmsk;
   word_t   s1_wdat;
   logic    ce;

   // Freeze both stages on a stage-2 miss or while the miss handler works
   assign ce = ~lk.hold & ~(lk.s2_valid & ~lk.hit);
   assign req_ready = ce;
   assign lk.ce = ce;
   assign lk.s1_index = s1_index;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         s1_valid    <= 1'b0;
         lk.s2_valid <= 1'b0;
         resp_valid  <= 1'b0;
      end
      else
      begin
         // A stage-2 request that advances has hit
         resp_valid <= ce & lk.s2_valid;
         if (ce)
         begin
            s1_valid    <= req_valid;
            lk.s2_valid <= s1_valid;
         end
      end
   end

   // Address split and store payload
   always_ff @(posedge clk)
   begin
      if (ce)
      begin
         s1_tag       <= req_addr[ADDR_W-1 -: TAG_W];
         s1_index     <= req_addr[BYTE_W+OFFSET_W +: INDEX_W];
         s1_offset    <= req_addr[BYTE_W +: OFFSET_W];
         s1_wmsk      <= req_wmsk;
         s1_wdat      <= req_wdat;
         lk.s2_tag    <= s1_tag;
         lk.s2_index  <= s1_index;
         lk.s2_offset <= s1_offset;
         lk.s2_wmsk   <= s1_wmsk;
         lk.s2_wdat   <= s1_wdat;
      end
   end

   assign resp_data = lk.hit_data;

   a_no_resp_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
      lk.hold |-> !resp_valid);

endmodule

//--- dcache_ways.sv
// Tag, valid, dirty and data arrays of all ways with the hit compare and way select
`timescale 1ns/1ps

module dcache_ways import dcache_pkg::*; (
   input logic    clk,
   lookup_if.ways lk,
   fill_if.ways   fl
);

   tag_entry_t                    tag_q [WAYS];
   word_t                         data_q [WAYS];
   wmsk_t                         d_we [WAYS];
   logic [WAYS-1:0]               hit_vec;
   logic [WAYS-1:0]               hit_q;
   logic [SETS-1:0]               dirty [WAYS];
   index_t                        t_addr;
   logic [INDEX_W+OFFSET_W-1:0]   d_addr;
   logic                          arr_re;
   logic                          st_commit;
   lane_t [WORD_BYTES-1:0]        wr_bytes;

   // The miss handler owns the arrays whenever it is not idle
   assign t_addr = fl.ovr ? fl.index : lk.s1_index;
   assign d_addr = fl.ovr ? {fl.index, fl.offset} : {lk.s2_index, lk.s2_offset};
   assign arr_re = lk.ce | fl.ovr;
   assign wr_bytes = fl.ovr ? fl.wdata : lk.s2_wdat;

   assign st_commit = lk.ce & lk.s2_valid & (|lk.s2_wmsk);

   genvar w;
   generate
      for (w = 0; w < WAYS; w++)
      begin : g_way
         assign hit_vec[w] = tag_q[w].valid & (tag_q[w].tag == lk.s2_tag);
         assign d_we[w] = fl.ovr ? {WORD_BYTES{fl.data_we & (fl.way == way_t'(w))}} :
                                   (st_commit & hit_vec[w] ? lk.s2_wmsk : '0);

         dcache_sram #(.entry_t(tag_entry_t), .DEPTH(SETS), .LANES(1)) u_tag (
            .clk  (clk),
            .addr (t_addr),
            .re   (arr_re),
            .we   (fl.valid_we[w]),
            .din  (tag_entry_t'{tag: fl.tag, valid: fl.valid}),
            .dout (tag_q[w])
         );

         dcache_sram #(.entry_t(word_t), .DEPTH(SETS*LINE_WORDS), .LANES(WORD_BYTES)) u_data (
            .clk  (clk),
            .addr (d_addr),
            .re   (arr_re),
            .we   (d_we[w]),
            .din  (word_t'(wr_bytes)),
            .dout (data_q[w])
         );

         // Dirty flags, cleared by boot and replace, set by a store hit
         always_ff @(posedge clk)
         begin
            if (fl.dirty_we[w])
               dirty[w][fl.index] <= 1'b0;
            else if (st_commit & hit_vec[w])
               dirty[w][lk.s2_index] <= 1'b1;
         end
      end
   endgenerate

   always_ff @(posedge clk)
   begin
      if (lk.ce)
         hit_q <= hit_vec;
   end

   always_comb
   begin
      lk.hit_data = data_q[0];
      for (int i = 0; i < WAYS; i++)
      begin
         if (hit_q[i])
            lk.hit_data = data_q[i];
      end
   end

   assign lk.hit = |hit_vec;
   assign lk.victim_dirty = dirty[fl.way][lk.s2_index];
   assign fl.victim_tag = tag_q[fl.way].tag;
   assign fl.victim_data = data_q[fl.way];

   a_one_hit: assert property (@(posedge clk) lk.s2_valid |-> $onehot0(hit_vec));

endmodule

//--- dcache_miss.sv
// Miss handler: boot sweep, victim choice, writeback and refill bursts over the memory bus
`timescale 1ns/1ps

module dcache_miss import dcache_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   lookup_if.miss lk,
   fill_if.miss   fl,
   output logic  ar_valid,
   input  logic  ar_ready,
   output addr_t ar_addr,
   input  logic  r_valid,
   output logic  r_ready,
   input  word_t r_data,
   input  logic  r_last,
   output logic  aw_valid,
   input  logic  aw_ready,
   output addr_t aw_addr,
   output logic  w_valid,
   input  logic  w_ready,
   output word_t w_data,
   output logic  w_last,
   input  logic  b_valid,
   output logic  b_ready
);

   miss_state_e     state, state_d;
   index_t          boot_cnt;
   way_t            victim;
   offset_t         beat;
   logic            miss;
   logic            set_ar;
   logic            set_aw;
   logic            r_hs;
   logic            w_hs;
   logic            b_hs;
   logic [WAYS-1:0] way_we;

   assign miss = lk.s2_valid & ~lk.hit;
   assign r_hs = r_valid & r_ready;
   assign w_hs = w_valid & w_ready;
   assign b_hs = b_valid & b_ready;

   assign set_aw = (state == REPLACE) & lk.victim_dirty;
   assign set_ar = ((state == REPLACE) & ~lk.victim_dirty) | ((state == WRITEBACK) & b_hs);

   always_comb
   begin
      state_d = state;
      case (state)
         BOOT:      if (boot_cnt == index_t'(SETS-1)) state_d = IDLE;
         IDLE:      if (miss) state_d = REPLACE;
         REPLACE:   state_d = lk.victim_dirty ? WRITEBACK : REFILL;
         WRITEBACK: if (b_hs) state_d = REFILL;
         REFILL:    if (r_hs & r_last) state_d = REPLAY;
         REPLAY:    state_d = IDLE;
         default:   state_d = BOOT;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= BOOT;
         boot_cnt <= '0;
         victim   <= '0;
         beat     <= '0;
         ar_valid <= 1'b0;
         aw_valid <= 1'b0;
         w_valid  <= 1'b0;
      end
      else
      begin
         state <= state_d;
         if (state == BOOT)
            boot_cnt <= boot_cnt + 1'b1;
         // Round robin, the new value is the victim of this miss
         if ((state == IDLE) & miss)
            victim <= victim + 1'b1;
         if (w_hs | r_hs)
            beat <= beat + 1'b1;
         if (set_ar)
            ar_valid <= 1'b1;
         else if (ar_ready)
            ar_valid <= 1'b0;
         if (set_aw)
            aw_valid <= 1'b1;
         else if (aw_ready)
            aw_valid <= 1'b0;
         if (set_aw)
            w_valid <= 1'b1;
         else if (w_hs & w_last)
            w_valid <= 1'b0;
      end
   end

   // Line-aligned burst addresses, victim tag is still on the RAM output here
   always_ff @(posedge clk)
   begin
      if (state == REPLACE)
      begin
         ar_addr <= {lk.s2_tag, lk.s2_index, {(OFFSET_W+BYTE_W){1'b0}}};
         aw_addr <= {fl.victim_tag, lk.s2_index, {(OFFSET_W+BYTE_W){1'b0}}};
      end
   end

   assign r_ready = (state == REFILL);
   assign b_ready = (state == WRITEBACK);
   assign w_data  = fl.victim_data;
   assign w_last  = w_valid & (beat == offset_t'(LINE_WORDS-1));

   always_comb
   begin
      for (int i = 0; i < WAYS; i++)
         way_we[i] = (state == BOOT) | ((state == REPLACE) & (victim == way_t'(i)));
   end

   assign lk.hold     = (state != IDLE);
   assign fl.ovr      = (state != IDLE);
   assign fl.index    = (state == BOOT) ? boot_cnt : lk.s2_index;
   // Next writeback word is fetched on the beat that is taken
   assign fl.offset   = w_hs ? beat + 1'b1 : beat;
   assign fl.way      = victim;
   assign fl.wdata    = r_data;
   assign fl.tag      = lk.s2_tag;
   assign fl.valid    = (state != BOOT);
   assign fl.valid_we = way_we;
   assign fl.dirty_we = way_we;
   assign fl.data_we  = r_hs;

   a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid & ~ar_ready |=> ar_valid & $stable(ar_addr));
   a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      aw_valid & ~aw_ready |=> aw_valid & $stable(aw_addr));

endmodule

//--- dcache_top.sv
// Data cache top level with core request, response and memory bus ports
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  req_valid,
   output logic  req_ready,
   input  addr_t req_addr,
   input  wmsk_t req_wmsk,
   input  word_t req_wdat,
   output logic  resp_valid,
   output word_t resp_data,
   output logic  ar_valid,
   input  logic  ar_ready,
   output addr_t ar_addr,
   input  logic  r_valid,
   output logic  r_ready,
   input  word_t r_data,
   input  logic  r_last,
   output logic  aw_valid,
   input  logic  aw_ready,
   output addr_t aw_addr,
   output logic  w_valid,
   input  logic  w_ready,
   output word_t w_data,
   output logic  w_last,
   input  logic  b_valid,
   output logic  b_ready
);

   lookup_if lk ();
   fill_if   fl ();

   dcache_lookup u_lookup (
      .clk (clk), .rst_n (rst_n),
      .req_valid (req_valid), .req_ready (req_ready), .req_addr (req_addr),
      .req_wmsk (req_wmsk), .req_wdat (req_wdat),
      .resp_valid (resp_valid), .resp_data (resp_data), .lk (lk.lookup)
   );

   dcache_ways u_ways (.clk (clk), .lk (lk.ways), .fl (fl.ways));

   dcache_miss u_miss (
      .clk (clk), .rst_n (rst_n), .lk (lk.miss), .fl (fl.miss),
      .ar_valid (ar_valid), .ar_ready (ar_ready), .ar_addr (ar_addr),
      .r_valid (r_valid), .r_ready (r_ready), .r_data (r_data), .r_last (r_last),
      .aw_valid (aw_valid), .aw_ready (aw_ready), .aw_addr (aw_addr),
      .w_valid (w_valid), .w_ready (w_ready), .w_data (w_data), .w_last (w_last),
      .b_valid (b_valid), .b_ready (b_ready)
   );

endmodule

//--- tb_clock.sv
// Testbench clock and reset source, 10 ns period with reset held low for 8 cycles
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Released on the eighth rising edge
   initial
   begin
      rst_n <= 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

//--- tb_mem.sv
// Backing memory of the cache testbench, answers read and write bursts with random stalls
`timescale 1ns/1ps

module tb_mem import dcache_pkg::*; #(
   parameter logic [31:0] SEED      = 32'hd9bb_dfa0,
   parameter int          MEM_WORDS = 256,
   parameter int          STALL_MAX = 6
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  ar_valid,
   output logic  ar_ready,
   input  addr_t ar_addr,
   output logic  r_valid,
   input  logic  r_ready,
   output word_t r_data,
   output logic  r_last,
   input  logic  aw_valid,
   output logic  aw_ready,
   input  addr_t aw_addr,
   input  logic  w_valid,
   output logic  w_ready,
   input  word_t w_data,
   input  logic  w_last,
   output logic  b_valid,
   input  logic  b_ready
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   word_t            mem [MEM_WORDS];
   integer           seed = SEED;
   int               stall;
   logic             r_busy;
   logic             aw_got;
   offset_t          rd_beat;
   logic [IDX_W-1:0] rd_word;
   logic [IDX_W-1:0] wr_word;

   // Each word depends on its full index
   initial
   begin
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = SEED ^ (i * 32'h9e37_79b9);
      ar_ready = 1'b0;
      r_valid  = 1'b0;
      r_data   = '0;
      r_last   = 1'b0;
      aw_ready = 1'b0;
      w_ready  = 1'b0;
      b_valid  = 1'b0;
   end

   always @(posedge clk)
   begin
      logic go;
      // Forced once the stall reaches its limit
      go = ($random(seed) & 1) || (stall >= STALL_MAX);
      if (!rst_n)
      begin
         stall    <= 0;
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
         r_last   <= 1'b0;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
         r_busy   <= 1'b0;
         aw_got   <= 1'b0;
      end
      else
      begin
         stall <= go ? 0 : stall + 1;
         // One read burst at a time
         if (ar_valid && ar_ready)
         begin
            ar_ready <= 1'b0;
            r_busy   <= 1'b1;
            rd_word  <= ar_addr[2 +: IDX_W];
            rd_beat  <= '0;
         end
         else
            ar_ready <= go && !r_busy;
         if (r_valid && r_ready)
         begin
            r_valid <= 1'b0;
            rd_word <= rd_word + 1'b1;
            rd_beat <= rd_beat + 1'b1;
            if (r_last)
               r_busy <= 1'b0;
         end
         else if (r_busy && !r_valid && go)
         begin
            r_valid <= 1'b1;
            r_data  <= mem[rd_word];
            r_last  <= (rd_beat == offset_t'(LINE_WORDS - 1));
         end
         // Write data only after its address
         if (aw_valid && aw_ready)
         begin
            aw_ready <= 1'b0;
            aw_got   <= 1'b1;
            wr_word  <= aw_addr[2 +: IDX_W];
         end
         else
            aw_ready <= go && !aw_got && !b_valid;
         if (w_valid && w_ready)
         begin
            mem[wr_word] <= w_data;
            wr_word      <= wr_word + 1'b1;
            w_ready      <= 1'b0;
            if (w_last)
            begin
               aw_got  <= 1'b0;
               b_valid <= 1'b1;
            end
         end
         else
            w_ready <= go && aw_got;
         if (b_valid && b_ready)
            b_valid <= 1'b0;
      end
   end

endmodule

//--- tb_dcache.sv
// Testbench top of the data cache that drives directed and random traffic against a word model
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

   localparam logic [31:0] SEED = 32'hd9bb_dfa0;
   localparam int MEM_WORDS = 256;
   localparam int STALL_MAX = 6;
   localparam int N_RANDOM  = 400;
   localparam int N_OPS     = N_RANDOM + 50;
   // Worst miss is a writeback and a refill burst with every handshake fully stalled
   localparam int MISS_CYCLES = 2 * (LINE_WORDS + 2) * (STALL_MAX + 2) + 10;
   localparam int LIMIT_NS    = (N_OPS * MISS_CYCLES + 500) * 10;

   logic    clk;
   logic    rst_n;
   logic    req_valid;
   logic    req_ready;
   addr_t   req_addr;
   wmsk_t   req_wmsk;
   word_t   req_wdat;
   logic    resp_valid;
   word_t   resp_data;
   logic    ar_valid;
   logic    ar_ready;
   logic    r_valid;
   logic    r_ready;
   logic    r_last;
   logic    aw_valid;
   logic    aw_ready;
   logic    w_valid;
   logic    w_ready;
   logic    w_last;
   logic    b_valid;
   logic    b_ready;
   addr_t   ar_addr;
   addr_t   aw_addr;
   word_t   r_data;
   word_t   w_data;

   integer  seed = SEED;
   word_t   model [MEM_WORDS];
   word_t   exp_q [$];
   addr_t   rd_bursts [$];
   addr_t   wr_bursts [$];
   word_t   wr_beats [$];
   offset_t w_cnt = '0;
   int      r_cnt = 0;
   int      errors = 0;
   int      n_acc = 0;
   int      n_resp = 0;

   tb_clock u_clock (.*);
   tb_mem #(.SEED(SEED), .MEM_WORDS(MEM_WORDS), .STALL_MAX(STALL_MAX)) u_mem (.*);
   dcache_top i_dut (.*);

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Holds one request until the cache takes it
   task automatic send(input addr_t addr, input wmsk_t wmsk, input word_t wdat);
      req_valid <= 1'b1;
      req_addr  <= addr;
      req_wmsk  <= wmsk;
      req_wdat  <= wdat;
      do
         @(posedge clk);
      while (req_ready !== 1'b1);
      req_valid <= 1'b0;
   endtask

   // The last accepted request is queued by the monitor on the same edge
   task automatic drain();
      @(posedge clk);
      while (exp_q.size() != 0)
         @(posedge clk);
      @(posedge clk);
   endtask

   task automatic test_done(input string name);
      $display("%s finished, %0d errors so far", name, errors);
   endtask

   // Checks responses in request order and logs the bus bursts
   always @(posedge clk)
   begin
      if (rst_n === 1'b1)
      begin
         if (resp_valid)
         begin
            n_resp++;
            if (exp_q.size() == 0)
            begin
               $display("ERROR: response arrived with no request outstanding");
               errors++;
            end
            else
               check("resp_data", resp_data, exp_q.pop_front());
         end
         if (req_valid && req_ready)
         begin
            n_acc++;
            exp_q.push_back(model[req_addr[9:2]]);
            for (int b = 0; b < WORD_BYTES; b++)
               if (req_wmsk[b])
                  model[req_addr[9:2]][8*b +: 8] = req_wdat[8*b +: 8];
         end
         if (ar_valid && ar_ready)
         begin
            check("ar_addr[3:0]", ar_addr[3:0], 4'h0);
            rd_bursts.push_back(ar_addr);
         end
         if (r_valid && r_ready)
            r_cnt++;
         if (aw_valid && aw_ready)
         begin
            check("aw_addr[3:0]", aw_addr[3:0], 4'h0);
            wr_bursts.push_back(aw_addr);
         end
         if (w_valid && w_ready)
         begin
            check("w_last", w_last, w_cnt == offset_t'(LINE_WORDS - 1));
            wr_beats.push_back(w_data);
            w_cnt <= w_cnt + 1'b1;
         end
      end
   end

   initial
   begin
      int    cycles;
      addr_t addr;
      wmsk_t wmsk;
      req_valid <= 1'b0;
      req_addr  <= '0;
      req_wmsk  <= '0;
      req_wdat  <= '0;
      do
         @(posedge clk);
      while (rst_n !== 1'b1);
      for (int i = 0; i < MEM_WORDS; i++)
         model[i] = u_mem.mem[i];

      // Boot sweep with a quiet bus
      cycles = 0;
      while (req_ready !== 1'b1 && cycles < SETS + 4)
      begin
         check("ar_valid", ar_valid, 1'b0);
         check("aw_valid", aw_valid, 1'b0);
         check("w_valid", w_valid, 1'b0);
         check("r_ready", r_ready, 1'b0);
         check("b_ready", b_ready, 1'b0);
         @(posedge clk);
         cycles++;
      end
      if (req_ready !== 1'b1)
      begin
         $display("ERROR: req_ready stayed low after the boot sweep");
         errors++;
      end
      test_done("boot");

      send(32'h0000_01a4, 4'h0, '0);
      drain();
      check("read bursts", rd_bursts.size(), 1);
      check("ar_addr", rd_bursts[0], 32'h0000_01a0);
      check("read beats", r_cnt, LINE_WORDS);
      test_done("first load");

      // Store then load on each word of the resident line
      for (int i = 0; i < 12; i++)
      begin
         addr = 32'h0000_01a0 + 4 * ((i / 2) % LINE_WORDS);
         wmsk = (i % 2 == 0) ? (wmsk_t'($random(seed)) | 4'h1) : 4'h0;
         send(addr, wmsk, $random(seed));
      end
      drain();
      test_done("back-to-back hits");

      // Three more lines in set 0xa push out the dirty line
      wr_bursts.delete();
      wr_beats.delete();
      send(32'h0000_02a0, '0, '0);
      drain();
      send(32'h0000_03a0, '0, '0);
      drain();
      send(32'h0000_00a0, '0, '0);
      drain();
      check("write bursts", wr_bursts.size(), 1);
      check("aw_addr", wr_bursts[0], 32'h0000_01a0);
      check("write beats", wr_beats.size(), LINE_WORDS);
      for (int i = 0; i < LINE_WORDS; i++)
         check("w_data", wr_beats[i], model[(32'h1a0 >> 2) + i]);
      for (int i = 0; i < LINE_WORDS; i++)
         send(32'h0000_01a0 + 4 * i, '0, '0);
      drain();
      test_done("dirty eviction");

      for (int i = 0; i < N_RANDOM; i++)
      begin
         addr = $random(seed) & 32'h0000_03fc;
         wmsk = ($random(seed) & 1) ? wmsk_t'($random(seed)) : 4'h0;
         send(addr, wmsk, $random(seed));
         if (($random(seed) & 7) == 0)
            @(posedge clk);
      end
      drain();
      check("responses", n_resp, n_acc);
      test_done("random mix");

      $display("requests %0d, responses %0d, errors %0d", n_acc, n_resp, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      #(LIMIT_NS);
      $display("ERROR: run timed out before all requests were answered");
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- project.f
dcache_pkg.sv
dcache_if.sv
dcache_sram.sv
dcache_lookup.sv
dcache_ways.sv
dcache_miss.sv
dcache_top.sv
tb_clock.sv
tb_mem.sv
tb_dcache.sv
